/* rtl/backend_top.sv */
module backend_top #(
    parameter int num_save = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic                 in_valid,
    input  cpu_pkg::u32_t        in_pc,
    input  cpu_pkg::reg_idx_t    in_rd,
    input  logic                 in_wr_rd,
    input  logic                 in_link,
    input  logic                 in_wr_csr,
    input  cpu_pkg::csr_addr_t   in_csr_addr,
    input  cpu_pkg::u32_t        in_result,
    input  logic                 in_is_load,
    input  cpu_pkg::load_size_t  in_load_size,
    input  logic                 in_load_signed,
    input  cpu_pkg::u32_t        in_load_data,
    input  logic                 in_excp,
    input  cpu_pkg::ecode_t      in_ecode,

    input  logic                 stall,
    input  logic                 flush,

    input  cpu_pkg::reg_idx_t    rs_idx,
    output cpu_pkg::u32_t        rs_data,
    input  cpu_pkg::csr_addr_t   csr_rd_addr,
    output cpu_pkg::u32_t        csr_rd_data,

    output logic                 commit_valid,
    output cpu_pkg::u32_t        commit_pc,
    output logic                 excp_flush
);
    import cpu_pkg::*;

    // mem2 to writeback
    logic      m2_valid;
    u32_t      m2_pc;
    reg_idx_t  m2_rd;
    logic      m2_wr_rd;
    logic      m2_link;
    logic      m2_wr_csr;
    csr_addr_t m2_csr_addr;
    u32_t      m2_value;
    logic      m2_excp;
    ecode_t    m2_ecode;

    // Write ports into the two files
    reg_idx_t  reg_idx;
    logic      reg_we;
    u32_t      reg_data;
    csr_addr_t csr_addr;
    logic      csr_we;
    u32_t      csr_data;
    logic      excp_we;
    u32_t      excp_pc;
    ecode_t    excp_ecode;

    mem2_stage u_mem2 (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall          (stall),
        .flush          (flush),
        .excp_flush     (excp_flush),
        .in_valid       (in_valid),
        .in_pc          (in_pc),
        .in_rd          (in_rd),
        .in_wr_rd       (in_wr_rd),
        .in_link        (in_link),
        .in_wr_csr      (in_wr_csr),
        .in_csr_addr    (in_csr_addr),
        .in_result      (in_result),
        .in_is_load     (in_is_load),
        .in_load_size   (in_load_size),
        .in_load_signed (in_load_signed),
        .in_load_data   (in_load_data),
        .in_excp        (in_excp),
        .in_ecode       (in_ecode),
        .m2_valid       (m2_valid),
        .m2_pc          (m2_pc),
        .m2_rd          (m2_rd),
        .m2_wr_rd       (m2_wr_rd),
        .m2_link        (m2_link),
        .m2_wr_csr      (m2_wr_csr),
        .m2_csr_addr    (m2_csr_addr),
        .m2_value       (m2_value),
        .m2_excp        (m2_excp),
        .m2_ecode       (m2_ecode)
    );

    writeback u_wb (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .flush        (flush),
        .m2_valid     (m2_valid),
        .m2_pc        (m2_pc),
        .m2_rd        (m2_rd),
        .m2_wr_rd     (m2_wr_rd),
        .m2_link      (m2_link),
        .m2_wr_csr    (m2_wr_csr),
        .m2_csr_addr  (m2_csr_addr),
        .m2_value     (m2_value),
        .m2_excp      (m2_excp),
        .m2_ecode     (m2_ecode),
        .reg_idx      (reg_idx),
        .reg_we       (reg_we),
        .reg_data     (reg_data),
        .csr_addr     (csr_addr),
        .csr_we       (csr_we),
        .csr_data     (csr_data),
        .excp_we      (excp_we),
        .excp_pc      (excp_pc),
        .excp_ecode   (excp_ecode),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .excp_flush   (excp_flush)
    );

    regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .reg_idx  (reg_idx),
        .reg_we   (reg_we),
        .reg_data (reg_data),
        .rs_idx   (rs_idx),
        .rs_data  (rs_data)
    );

    csr_file #(
        .num_save (num_save)
    ) u_csr (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_addr    (csr_addr),
        .csr_we      (csr_we),
        .csr_data    (csr_data),
        .excp_we     (excp_we),
        .excp_pc     (excp_pc),
        .excp_ecode  (excp_ecode),
        .csr_rd_addr (csr_rd_addr),
        .csr_rd_data (csr_rd_data)
    );

endmodule

/* rtl/cpu_pkg.sv */
package cpu_pkg;

    typedef logic [31:0] u32_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [13:0] csr_addr_t;
    typedef logic [5:0]  ecode_t;

    typedef enum logic [1:0] {
        load_byte = 2'd0,
        load_half = 2'd1,
        load_word = 2'd2
    } load_size_t;

    // One data word seen as bytes or as halves, little endian lanes
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } word_view_t;

    localparam csr_addr_t csr_crmd      = 14'h0;
    localparam csr_addr_t csr_prmd      = 14'h1;
    localparam csr_addr_t csr_estat     = 14'h5;
    localparam csr_addr_t csr_era       = 14'h6;
    localparam csr_addr_t csr_save_base = 14'h30; // Save registers sit at 0x30 upward

endpackage

/* rtl/csr_file.sv */
module csr_file #(
    parameter int num_save = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu_pkg::csr_addr_t  csr_addr,
    input  logic                csr_we,
    input  cpu_pkg::u32_t       csr_data,
    input  logic                excp_we,
    input  cpu_pkg::u32_t       excp_pc,
    input  cpu_pkg::ecode_t     excp_ecode,
    input  cpu_pkg::csr_addr_t  csr_rd_addr,
    output cpu_pkg::u32_t       csr_rd_data
);
    import cpu_pkg::*;

    u32_t crmd;
    u32_t prmd;
    u32_t estat;
    u32_t era;
    u32_t save_r [num_save];
    logic save_wr_hit;
    logic save_rd_hit;

    // Save block starts on a 16-aligned address, low nibble is the index
    assign save_wr_hit = (csr_addr[13:4] == csr_save_base[13:4]) && (csr_addr[3:0] < num_save);
    assign save_rd_hit = (csr_rd_addr[13:4] == csr_save_base[13:4])
                         && (csr_rd_addr[3:0] < num_save);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            crmd  <= 32'h8;
            prmd  <= '0;
            estat <= '0;
            era   <= '0;
        end else if (excp_we) begin
            prmd         <= {29'd0, crmd[2:0]};
            crmd[1:0]    <= 2'b00;            // Drop to privilege level 0
            era          <= excp_pc;
            estat[21:16] <= excp_ecode;
        end else if (csr_we) begin
            case (csr_addr)
                csr_crmd:  crmd  <= csr_data;
                csr_prmd:  prmd  <= csr_data;
                csr_estat: estat <= csr_data;
                csr_era:   era   <= csr_data;
                default:   ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_save; i++) begin
                save_r[i] <= '0;
            end
        end else if (csr_we && !excp_we && save_wr_hit) begin
            for (int i = 0; i < num_save; i++) begin
                if (csr_addr[3:0] == 4'(i)) begin
                    save_r[i] <= csr_data;
                end
            end
        end
    end

    always_comb begin
        csr_rd_data = '0;                      // Unmapped reads return zero
        case (csr_rd_addr)
            csr_crmd:  csr_rd_data = crmd;
            csr_prmd:  csr_rd_data = prmd;
            csr_estat: csr_rd_data = estat;
            csr_era:   csr_rd_data = era;
            default: begin
                for (int i = 0; i < num_save; i++) begin
                    if (save_rd_hit && csr_rd_addr[3:0] == 4'(i)) begin
                        csr_rd_data = save_r[i];
                    end
                end
            end
        endcase
    end

endmodule

/* rtl/mem2_stage.sv */
module mem2_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,
    input  logic                 flush,
    input  logic                 excp_flush,

    input  logic                 in_valid,
    input  cpu_pkg::u32_t        in_pc,
    input  cpu_pkg::reg_idx_t    in_rd,
    input  logic                 in_wr_rd,
    input  logic                 in_link,
    input  logic                 in_wr_csr,
    input  cpu_pkg::csr_addr_t   in_csr_addr,
    input  cpu_pkg::u32_t        in_result,
    input  logic                 in_is_load,
    input  cpu_pkg::load_size_t  in_load_size,
    input  logic                 in_load_signed,
    input  cpu_pkg::u32_t        in_load_data,
    input  logic                 in_excp,
    input  cpu_pkg::ecode_t      in_ecode,

    output logic                 m2_valid,
    output cpu_pkg::u32_t        m2_pc,
    output cpu_pkg::reg_idx_t    m2_rd,
    output logic                 m2_wr_rd,
    output logic                 m2_link,
    output logic                 m2_wr_csr,
    output cpu_pkg::csr_addr_t   m2_csr_addr,
    output cpu_pkg::u32_t        m2_value,
    output logic                 m2_excp,
    output cpu_pkg::ecode_t      m2_ecode
);
    import cpu_pkg::*;

    word_view_t  load_view;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    u32_t        load_value;
    u32_t        next_value;

    always_comb begin
        load_view = in_load_data;
        sel_byte  = load_view.bytes[in_result[1:0]];
        sel_half  = load_view.halves[in_result[1]];   // Offset bit 0 ignored for halves
        case (in_load_size)
            load_byte: load_value = {{24{in_load_signed & sel_byte[7]}}, sel_byte};
            load_half: load_value = {{16{in_load_signed & sel_half[15]}}, sel_half};
            default:   load_value = load_view;
        endcase
    end

    assign next_value = in_is_load ? load_value : in_result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m2_valid <= 1'b0;
        end else if (flush || excp_flush) begin
            m2_valid <= 1'b0;            // Squash on pipeline or exception flush
        end else if (!stall) begin
            m2_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            m2_pc       <= in_pc;
            m2_rd       <= in_rd;
            m2_wr_rd    <= in_wr_rd;
            m2_link     <= in_link;
            m2_wr_csr   <= in_wr_csr;
            m2_csr_addr <= in_csr_addr;
            m2_value    <= next_value;
            m2_excp     <= in_excp;
            m2_ecode    <= in_ecode;
        end
    end

endmodule

/* rtl/regfile.sv */
module regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  cpu_pkg::reg_idx_t  reg_idx,
    input  logic               reg_we,
    input  cpu_pkg::u32_t      reg_data,
    input  cpu_pkg::reg_idx_t  rs_idx,
    output cpu_pkg::u32_t      rs_data
);
    import cpu_pkg::*;

    u32_t regs [1:31];    // r0 has no storage

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_we && reg_idx != '0) begin
            regs[reg_idx] <= reg_data;
        end
    end

    assign rs_data = (rs_idx == '0) ? '0 : regs[rs_idx];

endmodule

/* rtl/writeback.sv */
module writeback (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stall,
    input  logic                flush,

    input  logic                m2_valid,
    input  cpu_pkg::u32_t       m2_pc,
    input  cpu_pkg::reg_idx_t   m2_rd,
    input  logic                m2_wr_rd,
    input  logic                m2_link,
    input  logic                m2_wr_csr,
    input  cpu_pkg::csr_addr_t  m2_csr_addr,
    input  cpu_pkg::u32_t       m2_value,
    input  logic                m2_excp,
    input  cpu_pkg::ecode_t     m2_ecode,

    output cpu_pkg::reg_idx_t   reg_idx,
    output logic                reg_we,
    output cpu_pkg::u32_t       reg_data,
    output cpu_pkg::csr_addr_t  csr_addr,
    output logic                csr_we,
    output cpu_pkg::u32_t       csr_data,
    output logic                excp_we,
    output cpu_pkg::u32_t       excp_pc,
    output cpu_pkg::ecode_t     excp_ecode,
    output logic                commit_valid,
    output cpu_pkg::u32_t       commit_pc,
    output logic                excp_flush
);
    import cpu_pkg::*;

    logic      wb_valid;
    u32_t      wb_pc;
    reg_idx_t  wb_rd;
    logic      wb_wr_rd;
    logic      wb_link;
    logic      wb_wr_csr;
    csr_addr_t wb_csr_addr;
    u32_t      wb_value;
    logic      wb_excp;
    ecode_t    wb_ecode;
    u32_t      pc_plus4;
    logic      live;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else if (flush || excp_flush) begin
            wb_valid <= 1'b0;
        end else if (!stall) begin
            wb_valid <= m2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            wb_pc       <= m2_pc;
            wb_rd       <= m2_rd;
            wb_wr_rd    <= m2_wr_rd;
            wb_link     <= m2_link;
            wb_wr_csr   <= m2_wr_csr;
            wb_csr_addr <= m2_csr_addr;
            wb_value    <= m2_value;
            wb_excp     <= m2_excp;
            wb_ecode    <= m2_ecode;
        end
    end

    // Held instruction acts only in its first unstalled cycle
    assign live     = wb_valid & ~stall & ~flush;
    assign pc_plus4 = wb_pc + 32'd4;

    assign commit_valid = live & ~wb_excp;
    assign commit_pc    = wb_pc;

    assign reg_idx  = wb_rd;
    assign reg_data = wb_link ? pc_plus4 : wb_value;
    assign reg_we   = commit_valid & wb_wr_rd;

    assign csr_addr = wb_csr_addr;
    assign csr_data = reg_data;                    // Same value as the register port
    assign csr_we   = commit_valid & wb_wr_csr;

    assign excp_we    = live & wb_excp;
    assign excp_pc    = wb_pc;
    assign excp_ecode = wb_ecode;
    assign excp_flush = excp_we;

endmodule

/* run.sh */
#!/bin/bash
# Build and run the backend testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module backend_tb -f tb.f \
    || { echo "Build failed"; exit 1; }
./obj_dir/Vbackend_tb > sim.log 2>&1
cat sim.log
grep -q "Regression failed" sim.log && { echo "FAIL"; exit 1; } \
    || { grep -q "Regression passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }; }

/* tb.f */
rtl/cpu_pkg.sv
rtl/mem2_stage.sv
rtl/writeback.sv
rtl/regfile.sv
rtl/csr_file.sv
rtl/backend_top.sv
verif/backend_assertions.sv
verif/backend_tb.sv

/* verif/backend_assertions.sv */
module backend_assertions (
    input logic clk,
    input logic rst_n,
    input logic stall,
    input logic flush,
    input logic wb_excp,
    input logic reg_we,
    input logic csr_we,
    input logic excp_we,
    input logic excp_flush
);

    // No file write while the held instruction is blocked or faulting
    no_write_when_blocked: assert property (
        @(posedge clk) disable iff (!rst_n)
        (stall || flush || wb_excp) |-> !(reg_we || csr_we)
    ) else $error("register or CSR write while blocked");

    excp_flush_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        excp_flush |=> !excp_flush
    ) else $error("excp_flush held longer than one cycle");

    excp_not_with_reg: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(excp_we && reg_we)
    ) else $error("excp_we together with reg_we");

endmodule

bind writeback backend_assertions u_asrt (
    .clk        (clk),
    .rst_n      (rst_n),
    .stall      (stall),
    .flush      (flush),
    .wb_excp    (wb_excp),
    .reg_we     (reg_we),
    .csr_we     (csr_we),
    .excp_we    (excp_we),
    .excp_flush (excp_flush)
);

/* verif/backend_tb.sv */
module backend_tb;
    import cpu_pkg::*;

    localparam int num_save = 4;
    localparam int max_entry_cycles = 18;   // Drive, flush, up to 15 stalls, slack

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        wr_rd;
        logic        link;
        logic        wr_csr;
        logic [13:0] csr_addr;
        logic [31:0] result;
        logic        is_load;
        logic [1:0]  size;
        logic        sgn;
        logic [31:0] ldata;
        logic        excp;
        logic [5:0]  ecode;
        logic [3:0]  stalls;
        logic        rnd_stall;
        logic        flush;
    } entry_t;

    logic clk = 1'b0;
    logic rst_n;
    logic in_valid, in_wr_rd, in_link, in_wr_csr, in_is_load, in_load_signed, in_excp;
    logic stall, flush;
    u32_t in_pc, in_result, in_load_data, rs_data, csr_rd_data, commit_pc;
    reg_idx_t in_rd, rs_idx;
    csr_addr_t in_csr_addr, csr_rd_addr;
    load_size_t in_load_size;
    ecode_t in_ecode;
    logic commit_valid, excp_flush;

    entry_t tbl[$];
    string  names[$];
    u32_t   exp_pc_q[$];
    string  exp_name_q[$];
    u32_t   sh_reg [32];
    u32_t   sh_crmd, sh_prmd, sh_estat, sh_era;
    u32_t   sh_save [16];
    logic   m2v, wbv;
    int     m2_e, wb_e;
    logic   exp_excp_flush = 1'b0;
    int     timeout_cycles = 0;
    logic   built = 1'b0;

    backend_top #(.num_save(num_save)) uut (.*);

    always #5 clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input u32_t expected, input u32_t actual);
        if (expected !== actual) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            report_failure("value mismatch");
        end
    endtask

    // Expected writeback value from the entry fields
    function automatic u32_t wb_value(input entry_t e);
        u32_t b;
        u32_t h;
        b = (e.ldata >> (8 * e.result[1:0])) & 32'hff;
        h = (e.ldata >> (16 * e.result[1])) & 32'hffff;
        if (e.link) return e.pc + 32'd4;
        if (!e.is_load) return e.result;
        if (e.size == 2'd0) return (e.sgn && b[7]) ? (b | 32'hffffff00) : b;
        if (e.size == 2'd1) return (e.sgn && h[15]) ? (h | 32'hffff0000) : h;
        return e.ldata;
    endfunction

    function automatic logic save_hit(input csr_addr_t a);
        return a[13:4] == 10'h3 && a[3:0] < num_save;
    endfunction

    function automatic u32_t csr_expect(input csr_addr_t a);
        if (a == 14'h0) return sh_crmd;
        if (a == 14'h1) return sh_prmd;
        if (a == 14'h5) return sh_estat;
        if (a == 14'h6) return sh_era;
        if (save_hit(a)) return sh_save[a[3:0]];
        return 32'h0;
    endfunction

    task automatic add_entry(input string name, input entry_t e);
        tbl.push_back(e);
        names.push_back(name);
    endtask

    function automatic entry_t alu(input u32_t pc, input int rd, input u32_t val, input int st);
        entry_t e;
        e = '0;
        e.pc = pc;
        e.rd = rd[4:0];
        e.wr_rd = 1'b1;
        e.result = val;
        e.stalls = st[3:0];
        return e;
    endfunction

    task automatic build_table();
        entry_t e;
        int k = 0;
        add_entry("alu_r1", alu(32'h100, 1, 32'h11111111, 0));
        add_entry("alu_r2", alu(32'h104, 2, 32'h22222222, 2));
        add_entry("alu_r0", alu(32'h108, 0, 32'hdeadbeef, 0));
        add_entry("alu_r3", alu(32'h10c, 3, 32'h33333333, 1));
        add_entry("alu_r6", alu(32'h110, 6, 32'h00000066, 3));
        add_entry("alu_r7", alu(32'h114, 7, 32'h00000077, 0));
        for (int sz = 0; sz < 3; sz++) begin
            for (int sg = 0; sg < 2; sg++) begin
                for (int off = 0; off < 4; off++) begin
                    e = alu(32'h200 + 4 * k, 8 + k, 32'h8000 + off, 0);
                    e.is_load   = 1'b1;
                    e.size      = sz[1:0];
                    e.sgn       = sg[0];
                    e.ldata     = 32'hf1827e93;
                    e.rnd_stall = 1'b1;
                    add_entry($sformatf("load_s%0d_x%0d_o%0d", sz, sg, off), e);
                    k++;
                end
            end
        end
        e = alu(32'h1000, 5, 32'h55555555, 0);
        e.link = 1'b1;
        add_entry("link_r5", e);
        e = alu(32'h300, 0, 32'h0000000b, 1);
        e.wr_rd = 1'b0;
        e.wr_csr = 1'b1;
        add_entry("csr_crmd", e);
        e.pc = 32'h304;
        e.csr_addr = 14'h1;
        e.result = 32'h5;
        add_entry("csr_prmd", e);
        e.pc = 32'h308;
        e.csr_addr = 14'h6;
        e.result = 32'h1234;
        add_entry("csr_era", e);
        e.pc = 32'h30c;
        e.csr_addr = 14'h2;
        e.result = 32'habc;
        add_entry("csr_unmapped", e);
        for (int i = 0; i < num_save; i++) begin
            e.pc = 32'h310 + 4 * i;
            e.csr_addr = 14'h30 + i[13:0];
            e.result = 32'h5a5a0000 + i;
            e.stalls = i[3:0];
            add_entry($sformatf("csr_save%0d", i), e);
        end
        add_entry("flush_old", alu(32'h400, 6, 32'h00000bad, 0));
        e = alu(32'h404, 7, 32'h0000bad2, 2);
        e.flush = 1'b1;                      // Flush right behind it kills both
        add_entry("flush_young", e);
        e = alu(32'h2000, 4, 32'h0000bad4, 0);
        e.wr_rd = 1'b0;
        e.excp = 1'b1;
        e.ecode = 6'h0c;
        add_entry("excp", e);
        add_entry("excp_young", alu(32'h2004, 4, 32'h0000bad3, 4));
        add_entry("alu_r4", alu(32'h2008, 4, 32'h44444444, 2));
        timeout_cycles = tbl.size() * max_entry_cycles + 200;
    endtask

    // Reference model of one cycle over the two pipeline slots
    task automatic model_step(input int cur, input logic st, input logic fl);
        entry_t e;
        logic exc;
        exc = 1'b0;
        if (wbv && !st && !fl) begin
            e = tbl[wb_e];
            if (e.excp) begin
                exc = 1'b1;
                sh_prmd = {29'd0, sh_crmd[2:0]};
                sh_crmd[1:0] = 2'b00;
                sh_era = e.pc;
                sh_estat[21:16] = e.ecode;
            end else begin
                exp_pc_q.push_back(e.pc);
                exp_name_q.push_back(names[wb_e]);
                if (e.wr_rd && e.rd != 0) sh_reg[e.rd] = wb_value(e);
                if (e.wr_csr) begin
                    case (e.csr_addr)
                        14'h0: sh_crmd = wb_value(e);
                        14'h1: sh_prmd = wb_value(e);
                        14'h5: sh_estat = wb_value(e);
                        14'h6: sh_era = wb_value(e);
                        default: if (save_hit(e.csr_addr)) sh_save[e.csr_addr[3:0]] = wb_value(e);
                    endcase
                end
            end
        end
        exp_excp_flush = exc;
        if (fl || exc) begin
            m2v = 1'b0;
            wbv = 1'b0;
        end else if (!st) begin
            wbv = m2v;
            m2v = (cur >= 0);
        end
        if (!st) begin
            wb_e = m2_e;
            m2_e = cur;
        end
    endtask

    task automatic drive_cycle(input int cur, input logic st, input logic fl);
        entry_t e;
        e = (cur >= 0) ? tbl[cur] : '0;
        @(posedge clk);
        in_valid       <= (cur >= 0);
        in_pc          <= e.pc;
        in_rd          <= e.rd;
        in_wr_rd       <= e.wr_rd;
        in_link        <= e.link;
        in_wr_csr      <= e.wr_csr;
        in_csr_addr    <= e.csr_addr;
        in_result      <= e.result;
        in_is_load     <= e.is_load;
        in_load_size   <= load_size_t'(e.size);
        in_load_signed <= e.sgn;
        in_load_data   <= e.ldata;
        in_excp        <= e.excp;
        in_ecode       <= e.ecode;
        stall          <= st;
        flush          <= fl;
        model_step(cur, st, fl);
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            check("excp_flush", {31'd0, exp_excp_flush}, {31'd0, excp_flush});
            if (commit_valid) begin
                if (exp_pc_q.size() == 0) begin
                    report_failure("commit seen with no instruction expected");
                end else begin
                    check({"commit_", exp_name_q.pop_front()}, exp_pc_q.pop_front(), commit_pc);
                end
            end
        end
    end

    initial begin
        wait (built);
        repeat (timeout_cycles) @(posedge clk);
        report_failure("watchdog timeout, pipeline did not finish");
    end

    initial begin
        int n;
        void'($urandom(35));
        rst_n <= 1'b0;
        rs_idx <= '0;
        csr_rd_addr <= '0;
        in_valid <= 1'b0;
        in_pc <= '0;
        in_rd <= '0;
        in_wr_rd <= 1'b0;
        in_link <= 1'b0;
        in_wr_csr <= 1'b0;
        in_csr_addr <= '0;
        in_result <= '0;
        in_is_load <= 1'b0;
        in_load_size <= load_byte;
        in_load_signed <= 1'b0;
        in_load_data <= '0;
        in_excp <= 1'b0;
        in_ecode <= '0;
        stall <= 1'b0;
        flush <= 1'b0;
        for (int i = 0; i < 32; i++) sh_reg[i] = '0;
        for (int i = 0; i < 16; i++) sh_save[i] = '0;
        sh_crmd = 32'h8;
        sh_prmd = '0;
        sh_estat = '0;
        sh_era = '0;
        m2v = 1'b0;
        wbv = 1'b0;
        m2_e = -1;
        wb_e = -1;
        build_table();
        built = 1'b1;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < tbl.size(); i++) begin
            drive_cycle(i, 1'b0, 1'b0);
            if (tbl[i].flush) drive_cycle(-1, 1'b0, 1'b1);
            n = tbl[i].rnd_stall ? int'($urandom % 4) : int'(tbl[i].stalls);
            repeat (n) drive_cycle(-1, 1'b1, 1'b0);
        end
        repeat (4) drive_cycle(-1, 1'b0, 1'b0);  // Drain
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            rs_idx <= i[4:0];
            @(negedge clk);
            check($sformatf("reg_r%0d", i), sh_reg[i], rs_data);
        end
        for (int a = 0; a < 14'h40; a++) begin
            @(posedge clk);
            csr_rd_addr <= a[13:0];
            @(negedge clk);
            check($sformatf("csr_%0h", a), csr_expect(a[13:0]), csr_rd_data);
        end
        if (exp_pc_q.size() != 0) begin
            report_failure("expected commits never appeared");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule
